//--- design/isaPkg.sv
package isaPkg;

    localparam int unsigned wordWidth = 16;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRtype = 4'd15   // function-coded group, JPR/JRL/WWD/HLT too
    } opcode_e;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } func_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        func_e      func;
    } rFormat_s;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iFormat_s;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] target;
    } jFormat_s;

    typedef union packed {
        rFormat_s r;
        iFormat_s i;
        jFormat_s j;
    } instrWord_u;

    // low eight values follow the R-type function codes
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOrr   = 4'd3,
        aluNot   = 4'd4,
        aluTcp   = 4'd5,
        aluShl   = 4'd6,
        aluShr   = 4'd7,
        aluPassB = 4'd8
    } aluOp_e;

endpackage

//--- design/busPkg.sv
package busPkg;

    localparam int unsigned addrWidth = 16;

    typedef enum logic [1:0] {
        ownIdle  = 2'd0,
        ownFetch = 2'd1,
        ownData  = 2'd2
    } requester_e;

endpackage

//--- design/regFile.sv
module regFile import isaPkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [1:0]           readAddrA,
    input  logic [1:0]           readAddrB,
    input  logic [1:0]           writeAddr,
    input  logic [wordWidth-1:0] writeData,
    input  logic                 writeEnable,
    output logic [wordWidth-1:0] readDataA,
    output logic [wordWidth-1:0] readDataB
);

    logic [wordWidth-1:0] regs [4];

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

//--- design/aluUnit.sv
module aluUnit import isaPkg::*; (
    input  logic [wordWidth-1:0] operandA,
    input  logic [wordWidth-1:0] operandB,
    input  aluOp_e               aluOp,
    output logic [wordWidth-1:0] result,
    output logic                 isZero,
    output logic                 isNegative
);

    always_comb begin
        case (aluOp)
            aluAdd:   result = operandA + operandB;
            aluSub:   result = operandA - operandB;
            aluAnd:   result = operandA & operandB;
            aluOrr:   result = operandA | operandB;
            aluNot:   result = ~operandA;
            aluTcp:   result = ~operandA + 1'b1;
            aluShl:   result = {operandA[wordWidth-2:0], 1'b0};
            aluShr:   result = {operandA[wordWidth-1], operandA[wordWidth-1:1]};  // arithmetic
            aluPassB: result = operandB;   // LHI
            default:  result = '0;
        endcase
    end

    // flags of the result, rs - rt or rs - 0 for branches
    assign isZero     = (result == '0);
    assign isNegative = result[wordWidth-1];

endmodule

//--- design/fetchUnit.sv
module fetchUnit import isaPkg::*, busPkg::*; #(
    parameter logic [addrWidth-1:0] resetVector = '0
) (
    input  logic                 clk,
    input  logic                 reset_n,
    output logic                 fetchReq,
    output logic [addrWidth-1:0] fetchAddr,
    input  logic                 fetchAck,
    input  logic [wordWidth-1:0] fetchRData,
    output logic [wordWidth-1:0] instr,
    output logic                 instrValid,
    input  logic                 instrTake,
    input  logic                 redirect,
    input  logic [addrWidth-1:0] redirectTarget
);

    logic [addrWidth-1:0] nextPc;
    logic                 waitAckLow;
    logic                 dropFetch;   // fetch in flight overtaken by a redirect
    logic                 startFetch;

    // buffer empty, or emptied this cycle
    assign startFetch = !fetchReq && !waitAckLow && !redirect && (!instrValid || instrTake);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            nextPc     <= resetVector;
            fetchReq   <= 1'b0;
            waitAckLow <= 1'b0;
            dropFetch  <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            if (instrTake || redirect) begin
                instrValid <= 1'b0;
            end
            if (startFetch) begin
                fetchReq <= 1'b1;
            end
            if (fetchReq && fetchAck) begin
                fetchReq   <= 1'b0;
                waitAckLow <= 1'b1;
                if (!dropFetch && !redirect) begin
                    instrValid <= 1'b1;
                    nextPc     <= fetchAddr + 1'b1;
                end
            end
            if (waitAckLow && !fetchAck) begin
                waitAckLow <= 1'b0;
                dropFetch  <= 1'b0;
            end
            if (redirect) begin
                nextPc <= redirectTarget;
                if (fetchReq && !fetchAck) begin
                    dropFetch <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startFetch) begin
            fetchAddr <= nextPc;
        end
        if (fetchReq && fetchAck) begin
            instr <= fetchRData;   // only marked valid when not dropped
        end
    end

endmodule

//--- design/datapath.sv
module datapath import isaPkg::*, busPkg::*; #(
    parameter logic [addrWidth-1:0] resetVector = '0
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [wordWidth-1:0] instr,
    input  logic                 instrValid,
    output logic                 instrTake,
    output logic                 redirect,
    output logic [addrWidth-1:0] redirectTarget,
    output logic                 dataReq,
    output logic                 dataWrite,
    output logic [addrWidth-1:0] dataAddr,
    output logic [wordWidth-1:0] dataWData,
    input  logic                 dataAck,
    input  logic [wordWidth-1:0] dataRData,
    output logic [wordWidth-1:0] outputPort,
    output logic                 outputValid,
    output logic [wordWidth-1:0] numInst,
    output logic                 halted
);

    instrWord_u           iw;
    opcode_e              op;
    func_e                fn;
    logic [addrWidth-1:0] execPc;
    logic [addrWidth-1:0] pcPlus1;
    logic [wordWidth-1:0] immSext;
    logic [wordWidth-1:0] immZext;
    logic [wordWidth-1:0] rsVal;
    logic [wordWidth-1:0] rtVal;
    logic [wordWidth-1:0] operandB;
    logic [wordWidth-1:0] aluResult;
    aluOp_e               aluOp;
    logic                 isZero;
    logic                 isNegative;
    logic                 isFuncGroup;
    logic                 isAluR;
    logic                 isBranch;
    logic                 isJumpReg;
    logic                 isLink;
    logic                 isMem;
    logic                 isWwd;
    logic                 isHlt;
    logic                 branchTaken;
    logic                 execute;
    logic                 memWaitLow;
    logic                 loadReturn;
    logic [1:0]           memRt;
    logic [1:0]           writeAddr;
    logic [wordWidth-1:0] writeData;
    logic                 writeEnable;

    assign iw          = instr;
    assign op          = iw.r.opcode;
    assign fn          = iw.r.func;
    assign immSext     = {{8{iw.i.imm[7]}}, iw.i.imm};
    assign immZext     = {8'h00, iw.i.imm};
    assign isFuncGroup = (op == opRtype);
    assign isAluR      = isFuncGroup && (iw.r.func[5:3] == 3'b000);
    assign isBranch    = op inside {opBne, opBeq, opBgz, opBlz};
    assign isJumpReg   = isFuncGroup && (fn == fnJpr || fn == fnJrl);
    assign isLink      = (op == opJal) || (isFuncGroup && fn == fnJrl);
    assign isMem       = (op == opLwd) || (op == opSwd);
    assign isWwd       = isFuncGroup && (fn == fnWwd);
    assign isHlt       = isFuncGroup && (fn == fnHlt);

    regFile regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .readAddrA  (iw.r.rs),
        .readAddrB  (iw.r.rt),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .writeEnable(writeEnable),
        .readDataA  (rsVal),
        .readDataB  (rtVal)
    );

    always_comb begin
        aluOp    = aluAdd;
        operandB = rtVal;
        case (op)
            opAdi, opLwd, opSwd: begin
                operandB = immSext;
            end
            opOri: begin
                aluOp    = aluOrr;
                operandB = immZext;
            end
            opLhi: begin
                aluOp    = aluPassB;
                operandB = {iw.i.imm, 8'h00};
            end
            opBne, opBeq: begin
                aluOp = aluSub;
            end
            opBgz, opBlz: begin
                aluOp    = aluSub;   // rs - 0 gives the flags of rs
                operandB = '0;
            end
            opRtype: begin
                aluOp = aluOp_e'({1'b0, iw.r.func[2:0]});
            end
            default: ;
        endcase
    end

    aluUnit alu (
        .operandA  (rsVal),
        .operandB  (operandB),
        .aluOp     (aluOp),
        .result    (aluResult),
        .isZero    (isZero),
        .isNegative(isNegative)
    );

    always_comb begin
        case (op)
            opBne:   branchTaken = !isZero;
            opBeq:   branchTaken = isZero;
            opBgz:   branchTaken = !isZero && !isNegative;
            opBlz:   branchTaken = isNegative;
            default: branchTaken = 1'b0;
        endcase
    end

    assign execute   = instrValid && !dataReq && !memWaitLow && !halted;
    // HLT stays in the buffer, which keeps fetch from starting again
    assign instrTake = execute && !isHlt;
    assign redirect  = execute && (branchTaken || op == opJmp || op == opJal || isJumpReg);
    assign pcPlus1   = execPc + 1'b1;

    always_comb begin
        if (isBranch) begin
            redirectTarget = pcPlus1 + immSext;
        end else if (isJumpReg) begin
            redirectTarget = rsVal;
        end else begin
            redirectTarget = {execPc[addrWidth-1:12], iw.j.target};
        end
    end

    assign loadReturn = dataReq && dataAck && !dataWrite;

    always_comb begin
        writeEnable = 1'b0;
        writeAddr   = iw.i.rt;
        writeData   = aluResult;
        if (loadReturn) begin
            writeEnable = 1'b1;
            writeAddr   = memRt;
            writeData   = dataRData;
        end else if (execute) begin
            if (isAluR) begin
                writeEnable = 1'b1;
                writeAddr   = iw.r.rd;
            end else if (op inside {opAdi, opOri, opLhi}) begin
                writeEnable = 1'b1;
            end else if (isLink) begin
                writeEnable = 1'b1;
                writeAddr   = 2'd2;   // link register
                writeData   = pcPlus1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            execPc      <= resetVector;
            dataReq     <= 1'b0;
            dataWrite   <= 1'b0;
            memWaitLow  <= 1'b0;
            outputValid <= 1'b0;
            numInst     <= '0;
            halted      <= 1'b0;
        end else begin
            outputValid <= execute && isWwd;
            if (instrTake) begin
                execPc <= redirect ? redirectTarget : pcPlus1;
            end
            if (execute) begin
                if (isHlt) begin
                    halted <= 1'b1;
                end
                if (isMem) begin
                    dataReq   <= 1'b1;
                    dataWrite <= (op == opSwd);
                end else begin
                    numInst <= numInst + 1'b1;
                end
            end
            if (dataReq && dataAck) begin
                dataReq    <= 1'b0;
                memWaitLow <= 1'b1;
            end
            if (memWaitLow && !dataAck) begin   // load/store done
                memWaitLow <= 1'b0;
                numInst    <= numInst + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (execute && isWwd) begin
            outputPort <= rsVal;
        end
        if (execute && isMem) begin
            dataAddr  <= aluResult;
            dataWData <= rtVal;
            memRt     <= iw.i.rt;
        end
    end

    // HLT stays buffered once the core halts
    haltNoTake: assert property (@(posedge clk) disable iff (reset_n)
        halted |-> instrValid && isHlt && !instrTake);

    // ack only inside a load/store handshake
    ackInHandshake: assert property (@(posedge clk) disable iff (reset_n)
        dataAck |-> dataReq || memWaitLow);

endmodule

//--- design/memArbiter.sv
module memArbiter import isaPkg::*, busPkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 fetchReq,
    input  logic [addrWidth-1:0] fetchAddr,
    output logic                 fetchAck,
    output logic [wordWidth-1:0] fetchRData,
    input  logic                 dataReq,
    input  logic                 dataWrite,
    input  logic [addrWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataWData,
    output logic                 dataAck,
    output logic [wordWidth-1:0] dataRData,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWData,
    input  logic                 memAck,
    input  logic [wordWidth-1:0] memRData
);

    requester_e owner;

    assign memReq     = (owner == ownData) ? dataReq : (owner == ownFetch) ? fetchReq : 1'b0;
    assign memWrite   = (owner == ownData) && dataWrite;
    assign memAddr    = (owner == ownData) ? dataAddr : fetchAddr;
    assign memWData   = dataWData;
    assign fetchAck   = (owner == ownFetch) && memAck;
    assign dataAck    = (owner == ownData) && memAck;
    assign fetchRData = memRData;
    assign dataRData  = memRData;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            owner <= ownIdle;
        end else if (owner == ownIdle) begin
            if (!memAck) begin
                if (dataReq) begin   // data wins a tie
                    owner <= ownData;
                end else if (fetchReq) begin
                    owner <= ownFetch;
                end
            end
        end else if (!memReq && !memAck) begin
            owner <= ownIdle;   // req dropped and ack fallen
        end
    end

    // owner, request and address held until the external ack
    ownedReq: assert property (@(posedge clk) disable iff (reset_n)
        memReq && !memAck |=> memReq && $stable(owner) && $stable(memAddr));

    // an external ack always goes to exactly one owner
    oneAck: assert property (@(posedge clk) disable iff (reset_n)
        memAck |-> fetchAck ^ dataAck);

endmodule

//--- design/cpuTop.sv
module cpuTop import isaPkg::*, busPkg::*; #(
    parameter logic [addrWidth-1:0] resetVector = '0
) (
    input  logic                 clk,
    input  logic                 reset_n,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWData,
    input  logic                 memAck,
    input  logic [wordWidth-1:0] memRData,
    output logic [wordWidth-1:0] outputPort,
    output logic                 outputValid,
    output logic [wordWidth-1:0] numInst,
    output logic                 halted
);

    logic                 fetchReq;
    logic [addrWidth-1:0] fetchAddr;
    logic                 fetchAck;
    logic [wordWidth-1:0] fetchRData;
    logic [wordWidth-1:0] instr;
    logic                 instrValid;
    logic                 instrTake;
    logic                 redirect;
    logic [addrWidth-1:0] redirectTarget;
    logic                 dataReq;
    logic                 dataWrite;
    logic [addrWidth-1:0] dataAddr;
    logic [wordWidth-1:0] dataWData;
    logic                 dataAck;
    logic [wordWidth-1:0] dataRData;

    // port names match the nets above
    fetchUnit #(.resetVector(resetVector)) fetch (.*);

    datapath #(.resetVector(resetVector)) core (.*);

    memArbiter arbiter (.*);

endmodule

//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [15:0] modelMem [65536];
logic [15:0] expWwd [$];
int          expCount;
bit          isStart [programLen];   // first word of a sequence
int          ctlKind [programLen];   // 1 branch, 2 jump, 3 jump through a register

function automatic logic [15:0] codeAddr(input int idx);
    return resetVector + 16'(idx);
endfunction

function automatic logic [15:0] iWord(input logic [3:0] op, input logic [1:0] rs,
                                      input logic [1:0] rt, input logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] rWord(input logic [5:0] fn, input logic [1:0] rs,
                                      input logic [1:0] rt, input logic [1:0] rd);
    return {4'hF, rs, rt, rd, fn};
endfunction

// forward by 1 to 4 words, always onto a sequence start
function automatic int pickTarget(input int from);
    int d;
    d = 1 + int'($urandom % 4);
    if (from + d > programLen - 1) begin
        d = programLen - 1 - from;
    end
    while (!isStart[from + d]) begin
        d--;
    end
    return from + d;
endfunction

task automatic generateProgram();
    int          i;
    int          kind;
    int          t;
    logic [1:0]  x;
    logic [15:0] ta;
    for (i = 0; i < programLen; i++) begin
        isStart[i] = 1'b0;
        ctlKind[i] = 0;
    end
    i = 0;
    while (i < programLen - 1) begin
        kind = int'($urandom % 16);
        if ((kind == 12 || kind == 13) && i > programLen - 3) begin
            kind = 0;
        end
        if (kind == 14 && i > programLen - 4) begin
            kind = 0;
        end
        isStart[i] = 1'b1;
        x = 2'($urandom);
        case (kind)
            5, 15: mem[codeAddr(i)] = iWord(opAdi, 2'($urandom), x, 8'($urandom));
            6: mem[codeAddr(i)] = iWord(opOri, 2'($urandom), x, 8'($urandom));
            7: mem[codeAddr(i)] = iWord(opLhi, 2'($urandom), x, 8'($urandom));
            8, 9: mem[codeAddr(i)] = rWord(fnWwd, x, 2'd0, 2'd0);
            10: ctlKind[i] = 1;
            11: ctlKind[i] = 2;
            12, 13: begin
                // base 0x0800, offset -8..127
                mem[codeAddr(i)] = iWord(opLhi, 2'd0, x, 8'h08);
                mem[codeAddr(i + 1)] = iWord(kind == 12 ? opLwd : opSwd, x, 2'($urandom),
                                             8'(int'($urandom % 136) - 8));
            end
            14: ctlKind[i] = 3;
            default: mem[codeAddr(i)] = rWord(6'($urandom % 8), 2'($urandom),
                                              2'($urandom), x);
        endcase
        i += (kind == 14) ? 3 : (kind == 12 || kind == 13) ? 2 : 1;
    end
    mem[codeAddr(programLen - 1)] = rWord(fnHlt, 2'd0, 2'd0, 2'd0);
    isStart[programLen - 1] = 1'b1;

    // targets once all sequence starts are known
    for (i = 0; i < programLen; i++) begin
        x = 2'($urandom);
        if (ctlKind[i] == 1) begin
            t = pickTarget(i);
            mem[codeAddr(i)] = iWord(4'($urandom % 4), x, 2'($urandom), 8'(t - i - 1));
        end else if (ctlKind[i] == 2) begin
            ta = codeAddr(pickTarget(i));
            mem[codeAddr(i)] = {(($urandom % 2) == 0) ? opJmp : opJal, ta[11:0]};
        end else if (ctlKind[i] == 3) begin
            ta = codeAddr(pickTarget(i + 2));
            mem[codeAddr(i)] = iWord(opLhi, 2'd0, x, ta[15:8]);
            mem[codeAddr(i + 1)] = iWord(opOri, x, x, ta[7:0]);
            mem[codeAddr(i + 2)] = rWord((($urandom % 2) == 0) ? fnJpr : fnJrl, x, 2'd0, 2'd0);
        end
    end
endtask

task automatic runModel();
    logic [15:0] r [4];
    logic [15:0] pc;
    logic [15:0] next;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] sx;
    instrWord_u  w;
    bit          done;
    int          k;
    for (k = 0; k < 4; k++) begin
        r[k] = '0;
    end
    pc = resetVector;
    done = 1'b0;
    expCount = 0;
    expWwd.delete();
    while (!done && expCount < 1000) begin
        w = modelMem[pc];
        a = r[w.r.rs];
        b = r[w.r.rt];
        sx = {{8{w.i.imm[7]}}, w.i.imm};
        next = pc + 16'd1;
        expCount++;
        case (w.r.opcode)
            opBne: if (a != b) next = pc + 16'd1 + sx;
            opBeq: if (a == b) next = pc + 16'd1 + sx;
            opBgz: if (!a[15] && a != 16'd0) next = pc + 16'd1 + sx;
            opBlz: if (a[15]) next = pc + 16'd1 + sx;
            opAdi: r[w.i.rt] = a + sx;
            opOri: r[w.i.rt] = a | {8'h00, w.i.imm};
            opLhi: r[w.i.rt] = {w.i.imm, 8'h00};
            opLwd: r[w.i.rt] = modelMem[a + sx];
            opSwd: modelMem[a + sx] = b;
            opJmp: next = {pc[15:12], w.j.target};
            opJal: begin
                r[2] = pc + 16'd1;
                next = {pc[15:12], w.j.target};
            end
            opRtype: begin
                case (w.r.func)
                    fnAdd: r[w.r.rd] = a + b;
                    fnSub: r[w.r.rd] = a - b;
                    fnAnd: r[w.r.rd] = a & b;
                    fnOrr: r[w.r.rd] = a | b;
                    fnNot: r[w.r.rd] = ~a;
                    fnTcp: r[w.r.rd] = 16'd0 - a;
                    fnShl: r[w.r.rd] = {a[14:0], 1'b0};
                    fnShr: r[w.r.rd] = {a[15], a[15:1]};
                    fnJpr: next = a;
                    fnJrl: begin
                        next = a;   // old rs, even when rs is the link register
                        r[2] = pc + 16'd1;
                    end
                    fnWwd: expWwd.push_back(a);
                    fnHlt: done = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        pc = next;
    end
endtask

`endif

//--- bench/cpuBench.sv
module cpuBench import isaPkg::*; ();

    localparam logic [15:0] resetVector = 16'h0040;
    localparam int programLen  = 60;
    localparam int haltTimeout = 4000;   // cycles
    localparam int quietCycles = 20;

    logic        clk;
    logic        reset_n;
    logic        memReq;
    logic        memWrite;
    logic [15:0] memAddr;
    logic [15:0] memWData;
    logic        memAck;
    logic [15:0] memRData;
    logic [15:0] outputPort;
    logic        outputValid;
    logic [15:0] numInst;
    logic        halted;

    logic [15:0] mem [65536];
    int          errors;
    int          wwdSeen;
    bit          pending;
    int          waitLeft;
    logic [15:0] holdAddr;
    logic [15:0] holdData;
    logic        holdWrite;

`include "isaModel.svh"

    cpuTop #(.resetVector(resetVector)) uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .memReq     (memReq),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memWData   (memWData),
        .memAck     (memAck),
        .memRData   (memRData),
        .outputPort (outputPort),
        .outputValid(outputValid),
        .numInst    (numInst),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] fillWord(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ (a << 5) ^ 16'h3c5a;
    endfunction

    task automatic checkQuiet(input string phase);
        assert (!memReq && !outputValid && !halted) else begin
            errors++;
            $display("%s: memReq, outputValid or halted is not low", phase);
        end
        assert (numInst == 16'd0) else begin
            errors++;
            $display("ERROR %s numInst: expected 0 actual %0d", phase, numInst);
        end
    endtask

    // external memory, ack after 0 to 3 cycles
    always @(posedge clk) begin
        if (reset_n) begin
            memAck <= 1'b0;
            pending = 1'b0;
        end else if (memAck) begin
            if (!memReq) begin
                memAck <= 1'b0;
            end
        end else if (memReq) begin
            if (!pending) begin
                pending   = 1'b1;
                holdAddr  = memAddr;
                holdData  = memWData;
                holdWrite = memWrite;
                waitLeft  = int'($urandom % 4);
            end else begin
                assert (memAddr == holdAddr && memWrite == holdWrite &&
                        (!holdWrite || memWData == holdData)) else begin
                    errors++;
                    $display("request at %h changed address or data before ack", holdAddr);
                end
            end
            if (waitLeft == 0) begin
                if (holdWrite) begin
                    mem[holdAddr] = holdData;
                end else begin
                    memRData <= mem[holdAddr];
                end
                memAck <= 1'b1;
                pending = 1'b0;
            end else begin
                waitLeft--;
            end
        end else begin
            assert (!pending) else begin
                errors++;
                $display("request at %h dropped before ack", holdAddr);
            end
            pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!reset_n && outputValid) begin
            assert (wwdSeen < expWwd.size()) else begin
                errors++;
                $display("more output pulses than the program produces");
            end
            if (wwdSeen < expWwd.size()) begin
                assert (outputPort == expWwd[wwdSeen]) else begin
                    errors++;
                    $display("ERROR output pulse %0d: expected %h actual %h",
                             wwdSeen, expWwd[wwdSeen], outputPort);
                end
            end
            wwdSeen++;
        end
    end

    initial begin
        int addr;
        int cycles;
        void'($urandom(32'hab93d6bc));
        errors = 0;
        wwdSeen = 0;
        pending = 1'b0;
        waitLeft = 0;
        reset_n = 1'b1;
        memAck = 1'b0;
        memRData = '0;
        for (addr = 0; addr < 65536; addr++) begin
            mem[16'(addr)] = fillWord(16'(addr));
        end
        generateProgram();
        for (addr = 0; addr < 65536; addr++) begin
            modelMem[16'(addr)] = mem[16'(addr)];
        end
        runModel();

        for (cycles = 0; cycles < 5; cycles++) begin
            @(posedge clk);
            if (cycles > 0) begin
                checkQuiet("reset");
            end
        end
        reset_n <= 1'b0;

        cycles = 0;
        while (!memReq && cycles < 20) begin   // idle until the first fetch
            @(posedge clk);
            if (!memReq) begin
                checkQuiet("after reset");
            end
            cycles++;
        end
        assert (memReq) else begin
            errors++;
            $display("no memory request within 20 cycles of reset");
        end

        cycles = 0;
        while (!halted && cycles < haltTimeout) begin
            @(posedge clk);
            cycles++;
        end
        assert (halted) else begin
            errors++;
            $display("halted did not rise within %0d cycles", haltTimeout);
        end
        assert (numInst == 16'(expCount)) else begin
            errors++;
            $display("ERROR instruction count: expected %0d actual %0d", expCount, numInst);
        end
        for (cycles = 0; cycles < quietCycles; cycles++) begin
            @(posedge clk);
            assert (!memReq) else begin
                errors++;
                $display("memory request after halt");
            end
        end

        assert (wwdSeen == expWwd.size()) else begin
            errors++;
            $display("ERROR output pulse count: expected %0d actual %0d", expWwd.size(), wwdSeen);
        end
        for (addr = 32'h07F8; addr <= 32'h087F; addr++) begin
            assert (mem[16'(addr)] == modelMem[16'(addr)]) else begin
                errors++;
                $display("ERROR data memory %h: expected %h actual %h",
                         16'(addr), modelMem[16'(addr)], mem[16'(addr)]);
            end
        end

        $display("errors: %0d  output pulses: %0d  instructions: %0d",
                 errors, wwdSeen, expCount);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+bench
design/isaPkg.sv
design/busPkg.sv
design/regFile.sv
design/aluUnit.sv
design/fetchUnit.sv
design/datapath.sv
design/memArbiter.sv
design/cpuTop.sv
bench/cpuBench.sv

//--- Makefile
# Verilator build and run for the 16-bit core
VERILATOR  ?= verilator
TOP        ?= cpuBench
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
FAIL_MSG   ?= Done: errors found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
